// File: logic/csr_apb_port.sv
// APB slave port
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_apb_port (
  input  logic               clk,
  input  logic               rst,
  input  csr_pkg::apb_req_t  apb_req,
  output csr_pkg::apb_rsp_t  apb_rsp,
  output csr_pkg::slot_wr_t  bus_wr,
  output csr_pkg::csr_addr_t rd_addr,
  output logic               rd_valid,
  input  csr_pkg::csr_word_t rd_data,
  input  logic               rd_hit
);

  logic                       access;
  logic                       wr_access;
  logic [`CSR_SLOT_COUNT-1:0] slot_sel;

  // One-hot writable slot for a CSR number, all zero when not writable
  function automatic logic [`CSR_SLOT_COUNT-1:0] decode_slot(
    input csr_pkg::csr_addr_t addr
  );
    logic [`CSR_SLOT_COUNT-1:0] sel;
    sel = '0;
    case (addr)
      `CSR_ADDR_MSTATUS:  sel[`CSR_SLOT_MSTATUS]  = 1'b1;
      `CSR_ADDR_MIE:      sel[`CSR_SLOT_MIE]      = 1'b1;
      `CSR_ADDR_MTVEC:    sel[`CSR_SLOT_MTVEC]    = 1'b1;
      `CSR_ADDR_MSCRATCH: sel[`CSR_SLOT_MSCRATCH] = 1'b1;
      `CSR_ADDR_MEPC:     sel[`CSR_SLOT_MEPC]     = 1'b1;
      `CSR_ADDR_MCAUSE:   sel[`CSR_SLOT_MCAUSE]   = 1'b1;
      `CSR_ADDR_MTVAL:    sel[`CSR_SLOT_MTVAL]    = 1'b1;
      `CSR_ADDR_MIP:      sel[`CSR_SLOT_MIP]      = 1'b1;
      default:            sel = '0;  // Read-only or unmapped
    endcase
    return sel;
  endfunction

  assign access    = apb_req.psel & apb_req.penable;  // Access phase
  assign wr_access = access & apb_req.pwrite;
  assign slot_sel  = decode_slot(apb_req.paddr);

  // Write lands at the edge that ends the access cycle
  assign bus_wr.en   = wr_access ? slot_sel : '0;
  assign bus_wr.data = apb_req.pwdata;

  assign rd_addr  = apb_req.paddr;
  assign rd_valid = access & ~apb_req.pwrite;

  // Zero wait states, every access completes at once
  assign apb_rsp.pready = access;

  // Writes must hit a slot, reads must hit anything the mux knows
  assign apb_rsp.pslverr = wr_access ? ~|slot_sel : (rd_valid & ~rd_hit);
  assign apb_rsp.prdata  = rd_data;

  penable_in_sel: assert property (@(posedge clk) disable iff (rst)
    apb_req.penable |-> apb_req.psel);

  // Address held from setup into access
  paddr_stable: assert property (@(posedge clk) disable iff (rst)
    (apb_req.psel && !apb_req.penable) ##1 (apb_req.psel && apb_req.penable)
      |-> $stable(apb_req.paddr));

endmodule

// File: logic/csr_params.svh
// CSR block parameters
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

`define CSR_XLEN 64
`define CSR_SLOT_COUNT 8

// Writable slot indices
`define CSR_SLOT_MSTATUS 0
`define CSR_SLOT_MIE 1
`define CSR_SLOT_MTVEC 2
`define CSR_SLOT_MSCRATCH 3
`define CSR_SLOT_MEPC 4
`define CSR_SLOT_MCAUSE 5
`define CSR_SLOT_MTVAL 6
`define CSR_SLOT_MIP 7

// CSR numbers as seen on paddr
`define CSR_ADDR_MSTATUS 12'h300
`define CSR_ADDR_MISA 12'h301
`define CSR_ADDR_MIE 12'h304
`define CSR_ADDR_MTVEC 12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC 12'h341
`define CSR_ADDR_MCAUSE 12'h342
`define CSR_ADDR_MTVAL 12'h343
`define CSR_ADDR_MIP 12'h344
`define CSR_ADDR_MCYCLE 12'hB00
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID 12'hF12
`define CSR_ADDR_MIMPID 12'hF13
`define CSR_ADDR_MHARTID 12'hF14

`define CSR_RST_MSTATUS 64'h0000_0000_0000_1800
`define CSR_RST_DEFAULT 64'h0000_0000_0000_0000

`define CSR_MASK_MSTATUS 64'h0000_0000_0000_1888
`define CSR_MASK_MIE 64'h0000_0000_0000_0888
`define CSR_MASK_MIP 64'h0000_0000_0000_0888
`define CSR_MASK_MTVEC 64'hFFFF_FFFF_FFFF_FFFC
`define CSR_MASK_MEPC 64'hFFFF_FFFF_FFFF_FFFC
`define CSR_MASK_FULL 64'hFFFF_FFFF_FFFF_FFFF

`define CSR_MISA_VALUE 64'h8000_0000_0000_0100

`endif

// File: logic/csr_pkg.sv
// CSR block types
`include "csr_params.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0] csr_word_t;
  typedef logic [11:0] csr_addr_t;

  // Machine status fields, machine mode only
  typedef struct packed {
    logic [63:13] rsvd_hi;
    logic [1:0]   mpp;      // 12:11
    logic [10:8]  rsvd_mid;
    logic         mpie;     // 7
    logic [6:4]   rsvd_lo;
    logic         mie;      // 3
    logic [2:0]   rsvd_low;
  } mstatus_fields_t;

  // Same word seen as a register value or as the trap stack
  typedef union packed {
    csr_word_t       raw;
    mstatus_fields_t fields;
  } mstatus_u;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    csr_addr_t paddr;
    csr_word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic      pready;
    logic      pslverr;
    csr_word_t prdata;
  } apb_rsp_t;

  typedef struct packed {
    logic      enter;
    logic      exit;
    csr_word_t pc;
    csr_word_t cause;
    csr_word_t tval;
  } trap_info_t;

  typedef struct packed {
    logic [`CSR_SLOT_COUNT-1:0] en;
    csr_word_t                  data;
  } slot_wr_t;

  // One word per writable slot
  typedef csr_word_t [`CSR_SLOT_COUNT-1:0] slot_words_t;

endpackage

// File: logic/csr_read_mux.sv
// CSR read multiplexer and cycle counter
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_read_mux (
  input  logic                 clk,
  input  logic                 rst,
  input  csr_pkg::slot_words_t slots,
  input  csr_pkg::csr_addr_t   rd_addr,
  input  logic                 rd_valid,
  output csr_pkg::csr_word_t   rd_data,
  output logic                 rd_hit
);

  csr_pkg::csr_word_t mcycle_q;

  // Free-running, counts from the first cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + 1'b1;
    end
  end

  always_comb begin
    rd_data = '0;
    rd_hit  = 1'b0;
    if (rd_valid) begin
      rd_hit = 1'b1;
      case (rd_addr)
        `CSR_ADDR_MSTATUS:  rd_data = slots[`CSR_SLOT_MSTATUS];
        `CSR_ADDR_MIE:      rd_data = slots[`CSR_SLOT_MIE];
        `CSR_ADDR_MTVEC:    rd_data = slots[`CSR_SLOT_MTVEC];  // Low bits held at 0 by mask
        `CSR_ADDR_MSCRATCH: rd_data = slots[`CSR_SLOT_MSCRATCH];
        `CSR_ADDR_MEPC:     rd_data = slots[`CSR_SLOT_MEPC];
        `CSR_ADDR_MCAUSE:   rd_data = slots[`CSR_SLOT_MCAUSE];
        `CSR_ADDR_MTVAL:    rd_data = slots[`CSR_SLOT_MTVAL];
        `CSR_ADDR_MIP:      rd_data = slots[`CSR_SLOT_MIP];
        `CSR_ADDR_MISA:     rd_data = `CSR_MISA_VALUE;
        `CSR_ADDR_MCYCLE:   rd_data = mcycle_q;
        // ID registers read as zero but are mapped
        `CSR_ADDR_MVENDORID,
        `CSR_ADDR_MARCHID,
        `CSR_ADDR_MIMPID,
        `CSR_ADDR_MHARTID:  rd_data = '0;
        default: begin
          rd_data = '0;
          rd_hit  = 1'b0;
        end
      endcase
    end
  end

endmodule

// File: logic/csr_slot.sv
// Writable CSR register slot
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_slot #(
  parameter csr_pkg::csr_word_t RESET_VALUE = '0,
  parameter csr_pkg::csr_word_t WRITE_MASK  = '1
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               bus_wr_en,
  input  csr_pkg::csr_word_t bus_wr_data,
  input  logic               trap_wr_en,
  input  csr_pkg::csr_word_t trap_wr_data,
  output csr_pkg::csr_word_t value
);

  csr_pkg::csr_word_t value_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      value_q <= RESET_VALUE;
    end else if (trap_wr_en) begin
      value_q <= trap_wr_data;  // Trap word stored whole
    end else if (bus_wr_en) begin
      value_q <= (value_q & ~WRITE_MASK) | (bus_wr_data & WRITE_MASK);
    end
  end

  assign value = value_q;

  // Fixed bits only move on a trap write
  fixed_bits_hold: assert property (@(posedge clk) disable iff (rst)
    !$past(trap_wr_en) |-> ((value ^ $past(value)) & ~WRITE_MASK) == '0);

endmodule

// File: logic/csr_top.sv
// Machine-mode CSR block
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_top (
  input  logic                clk,
  input  logic                rst,
  input  csr_pkg::apb_req_t   apb_req,
  output csr_pkg::apb_rsp_t   apb_rsp,
  input  csr_pkg::trap_info_t trap,
  output logic                redirect_valid,
  output csr_pkg::csr_word_t  redirect_pc
);

  csr_pkg::slot_wr_t    bus_wr;
  csr_pkg::slot_wr_t    trap_wr;
  csr_pkg::slot_words_t trap_wr_data;
  csr_pkg::slot_words_t slot_values;
  csr_pkg::csr_addr_t   rd_addr;
  logic                 rd_valid;
  csr_pkg::csr_word_t   rd_data;
  logic                 rd_hit;

  function automatic csr_pkg::csr_word_t slot_reset(input int unsigned idx);
    if (idx == `CSR_SLOT_MSTATUS) begin
      return `CSR_RST_MSTATUS;  // MPP = machine
    end
    return `CSR_RST_DEFAULT;
  endfunction

  function automatic csr_pkg::csr_word_t slot_mask(input int unsigned idx);
    case (idx)
      `CSR_SLOT_MSTATUS: return `CSR_MASK_MSTATUS;
      `CSR_SLOT_MIE:     return `CSR_MASK_MIE;
      `CSR_SLOT_MIP:     return `CSR_MASK_MIP;
      `CSR_SLOT_MTVEC:   return `CSR_MASK_MTVEC;
      `CSR_SLOT_MEPC:    return `CSR_MASK_MEPC;
      default:           return `CSR_MASK_FULL;
    endcase
  endfunction

  csr_apb_port i_apb_port (
    .clk      (clk),
    .rst      (rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .bus_wr   (bus_wr),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .rd_hit   (rd_hit)
  );

  for (genvar i = 0; i < `CSR_SLOT_COUNT; i++) begin : g_slot
    csr_slot #(
      .RESET_VALUE (slot_reset(i)),
      .WRITE_MASK  (slot_mask(i))
    ) i_slot (
      .clk          (clk),
      .rst          (rst),
      .bus_wr_en    (bus_wr.en[i]),
      .bus_wr_data  (bus_wr.data),
      .trap_wr_en   (trap_wr.en[i]),
      .trap_wr_data (trap_wr_data[i]),
      .value        (slot_values[i])
    );
  end

  csr_trap_seq i_trap_seq (
    .trap           (trap),
    .slots          (slot_values),
    .trap_wr        (trap_wr),
    .trap_wr_data   (trap_wr_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  csr_read_mux i_read_mux (
    .clk      (clk),
    .rst      (rst),
    .slots    (slot_values),
    .rd_addr  (rd_addr),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .rd_hit   (rd_hit)
  );

  // Trap stack update lands even against a bus write in the same cycle
  trap_status_lands: assert property (@(posedge clk) disable iff (rst)
    trap_wr.en[`CSR_SLOT_MSTATUS] |=> slot_values[`CSR_SLOT_MSTATUS] == $past(trap_wr.data));

endmodule

// File: logic/csr_trap_seq.sv
// Trap entry and return sequencer
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_trap_seq (
  input  csr_pkg::trap_info_t  trap,
  input  csr_pkg::slot_words_t slots,
  output csr_pkg::slot_wr_t    trap_wr,
  output csr_pkg::slot_words_t trap_wr_data,
  output logic                 redirect_valid,
  output csr_pkg::csr_word_t   redirect_pc
);

  csr_pkg::mstatus_u cur_status;
  csr_pkg::mstatus_u nxt_status;

  // Interrupt-enable stack update
  always_comb begin
    cur_status.raw = slots[`CSR_SLOT_MSTATUS];
    nxt_status     = cur_status;
    if (trap.enter) begin
      nxt_status.fields.mpie = cur_status.fields.mie;
      nxt_status.fields.mie  = 1'b0;
      nxt_status.fields.mpp  = 2'b11;  // Machine
    end else if (trap.exit) begin
      nxt_status.fields.mie  = cur_status.fields.mpie;
      nxt_status.fields.mpie = 1'b1;
    end
  end

  always_comb begin
    trap_wr.en   = '0;
    trap_wr.data = nxt_status.raw;  // mstatus is the word both events touch
    if (trap.enter) begin
      trap_wr.en[`CSR_SLOT_MSTATUS] = 1'b1;
      trap_wr.en[`CSR_SLOT_MEPC]    = 1'b1;
      trap_wr.en[`CSR_SLOT_MCAUSE]  = 1'b1;
      trap_wr.en[`CSR_SLOT_MTVAL]   = 1'b1;
    end else if (trap.exit) begin
      trap_wr.en[`CSR_SLOT_MSTATUS] = 1'b1;
    end
  end

  // Per-slot data, only the enabled entries matter
  always_comb begin
    trap_wr_data                     = '0;
    trap_wr_data[`CSR_SLOT_MSTATUS]  = nxt_status.raw;
    trap_wr_data[`CSR_SLOT_MEPC]     = {trap.pc[`CSR_XLEN-1:2], 2'b00};
    trap_wr_data[`CSR_SLOT_MCAUSE]   = trap.cause;
    trap_wr_data[`CSR_SLOT_MTVAL]    = trap.tval;
  end

  assign redirect_valid = trap.enter | trap.exit;

  always_comb begin
    if (trap.enter) begin
      redirect_pc = {slots[`CSR_SLOT_MTVEC][`CSR_XLEN-1:2], 2'b00};  // Direct mode only
    end else if (trap.exit) begin
      redirect_pc = slots[`CSR_SLOT_MEPC];
    end else begin
      redirect_pc = '0;
    end
  end

  // Pipeline never raises both in one cycle
  always_comb begin
    enter_exit_excl: assert (!(trap.enter && trap.exit));
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the CSR block testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module csr_tb \
  --Mdir obj_dir -o csr_tb_sim > build.log 2>&1 &&
./obj_dir/csr_tb_sim > sim.log 2>&1 ||
echo "Build or simulation ended with an error, see build.log and sim.log"

cat sim.log 2>/dev/null
grep -q "^=== PASS ===$" sim.log && echo "Simulation passed" && exit 0 ||
{ echo "Simulation failed"; exit 1; }

// File: sources.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_apb_port.sv
logic/csr_trap_seq.sv
logic/csr_slot.sv
logic/csr_read_mux.sv
logic/csr_top.sv
testbench/csr_tb.sv

// File: testbench/csr_tb.sv
// CSR block testbench
`timescale 1ns/10ps
`include "csr_params.svh"

module csr_tb;

  localparam int MAX_WAIT = 16;  // Cycles allowed for any handshake

  logic                clk;
  logic                rst;
  csr_pkg::apb_req_t   apb_req;
  csr_pkg::apb_rsp_t   apb_rsp;
  csr_pkg::trap_info_t trap;
  logic                redirect_valid;
  csr_pkg::csr_word_t  redirect_pc;
  string               test_name;

  // Slot tables in slot index order
  csr_pkg::csr_addr_t slot_addr [`CSR_SLOT_COUNT] = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MIE,
    `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL,
    `CSR_ADDR_MIP};
  csr_pkg::csr_word_t slot_mask [`CSR_SLOT_COUNT] = '{`CSR_MASK_MSTATUS, `CSR_MASK_MIE,
    `CSR_MASK_MTVEC, `CSR_MASK_FULL, `CSR_MASK_MEPC, `CSR_MASK_FULL, `CSR_MASK_FULL,
    `CSR_MASK_MIP};
  csr_pkg::csr_word_t slot_rst [`CSR_SLOT_COUNT] = '{`CSR_RST_MSTATUS, 64'h0, 64'h0, 64'h0,
    64'h0, 64'h0, 64'h0, 64'h0};
  csr_pkg::csr_word_t shadow [`CSR_SLOT_COUNT];  // Expected slot contents

  csr_top i_dut (
    .clk            (clk),
    .rst            (rst),
    .apb_req        (apb_req),
    .apb_rsp        (apb_rsp),
    .trap           (trap),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input csr_pkg::csr_word_t exp,
                            input csr_pkg::csr_word_t act);
    if (exp !== act) begin
      stop_run($sformatf("Error in %s: %s expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_resp(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      stop_run($sformatf("Error in %s: %s pslverr expected %b, actual %b",
                         test_name, what, exp, act));
    end
  endtask

  // Handshake flags such as pready and redirect_valid
  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      stop_run($sformatf("Error in %s: %s expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_mstatus(input csr_pkg::mstatus_u exp, input csr_pkg::mstatus_u act);
    if (exp.raw !== act.raw) begin
      stop_run({$sformatf("Error in %s: mstatus expected %h (mpp %0d mpie %b mie %b), ",
                          test_name, exp.raw, exp.fields.mpp, exp.fields.mpie,
                          exp.fields.mie),
                $sformatf("actual %h (mpp %0d mpie %b mie %b)",
                          act.raw, act.fields.mpp, act.fields.mpie, act.fields.mie)});
    end
  endtask

  function automatic csr_pkg::csr_word_t rand_word();
    return {$urandom(), $urandom()};
  endfunction

  // Writable bits from the bus, the rest keep their reset value
  function automatic csr_pkg::csr_word_t expect_write(input int idx,
                                                      input csr_pkg::csr_word_t data);
    return (data & slot_mask[idx]) | (slot_rst[idx] & ~slot_mask[idx]);
  endfunction

  task automatic apb_xfer(input logic write, input csr_pkg::csr_addr_t addr,
                          input csr_pkg::csr_word_t wdata,
                          output csr_pkg::csr_word_t rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    apb_req.psel    = 1'b1;  // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    check_flag("pready in setup", 1'b0, apb_rsp.pready);
    check_flag("pslverr in setup", 1'b0, apb_rsp.pslverr);
    @(posedge clk);
    #2;
    apb_req.penable = 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      waited++;
      if (waited > MAX_WAIT) begin
        stop_run($sformatf("APB transfer to %h saw no pready within %0d cycles",
                           addr, MAX_WAIT));
      end
      @(negedge clk);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);  // Write lands here
    #2;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_word_t data,
                           output logic err);
    csr_pkg::csr_word_t unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_word_t data,
                          output logic err);
    apb_xfer(1'b0, addr, '0, data, err);
  endtask

  task automatic trap_pulse(input logic enter, input csr_pkg::csr_word_t pc,
                            input csr_pkg::csr_word_t cause, input csr_pkg::csr_word_t tval,
                            output csr_pkg::csr_word_t target);
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    trap.enter = enter;
    trap.exit  = ~enter;
    trap.pc    = pc;
    trap.cause = cause;
    trap.tval  = tval;
    @(negedge clk);
    while (!redirect_valid) begin
      waited++;
      if (waited > MAX_WAIT) begin
        stop_run($sformatf("No redirect seen within %0d cycles of a trap pulse", MAX_WAIT));
      end
      @(negedge clk);
    end
    target = redirect_pc;
    @(posedge clk);  // CSR updates land here
    #2;
    trap = '0;
    @(negedge clk);
    check_flag("redirect_valid after trap pulse", 1'b0, redirect_valid);
  endtask

  task automatic trap_enter(input csr_pkg::csr_word_t pc, input csr_pkg::csr_word_t cause,
                            input csr_pkg::csr_word_t tval, output csr_pkg::csr_word_t target);
    trap_pulse(1'b1, pc, cause, tval, target);
  endtask

  task automatic trap_exit(output csr_pkg::csr_word_t target);
    trap_pulse(1'b0, '0, '0, '0, target);
  endtask

  task automatic read_reset_values();
    csr_pkg::csr_word_t data;
    logic               err;
    int                 i;
    test_name = "reset_values";
    apb_read(`CSR_ADDR_MISA, data, err);
    check_resp("misa read", 1'b0, err);
    check_word("misa", `CSR_MISA_VALUE, data);
    for (i = 0; i < `CSR_SLOT_COUNT; i++) begin
      apb_read(slot_addr[i], data, err);
      check_resp($sformatf("slot %0d read", i), 1'b0, err);
      check_word($sformatf("slot %0d", i), slot_rst[i], data);
      shadow[i] = slot_rst[i];
    end
    for (i = `CSR_ADDR_MVENDORID; i <= `CSR_ADDR_MHARTID; i++) begin  // ID registers
      apb_read(i[11:0], data, err);
      check_resp($sformatf("csr %h read", i), 1'b0, err);
      check_word($sformatf("csr %h", i), 64'h0, data);
    end
  endtask

  task automatic write_masked_values();
    csr_pkg::csr_word_t wdata;
    csr_pkg::csr_word_t data;
    logic               err;
    int                 i;
    test_name = "masked_writes";
    for (i = 0; i < `CSR_SLOT_COUNT; i++) begin
      wdata = rand_word();
      apb_write(slot_addr[i], wdata, err);
      check_resp($sformatf("slot %0d write", i), 1'b0, err);
      shadow[i] = expect_write(i, wdata);
      apb_read(slot_addr[i], data, err);
      check_resp($sformatf("slot %0d read", i), 1'b0, err);
      check_word($sformatf("slot %0d", i), shadow[i], data);
    end
  endtask

  task automatic provoke_bus_errors();
    csr_pkg::csr_word_t data;
    logic               err;
    int                 i;
    test_name = "errors";
    apb_read(12'h7C0, data, err);
    check_resp("unmapped read", 1'b1, err);
    apb_write(`CSR_ADDR_MISA, rand_word(), err);
    check_resp("misa write", 1'b1, err);
    apb_write(`CSR_ADDR_MCYCLE, rand_word(), err);
    check_resp("mcycle write", 1'b1, err);
    apb_write(`CSR_ADDR_MHARTID, rand_word(), err);
    check_resp("mhartid write", 1'b1, err);
    apb_read(`CSR_ADDR_MISA, data, err);
    check_word("misa after write", `CSR_MISA_VALUE, data);
    apb_read(`CSR_ADDR_MHARTID, data, err);
    check_word("mhartid after write", 64'h0, data);
    for (i = 0; i < `CSR_SLOT_COUNT; i++) begin  // Slots untouched
      apb_read(slot_addr[i], data, err);
      check_word($sformatf("slot %0d", i), shadow[i], data);
    end
  endtask

  task automatic take_trap();
    csr_pkg::csr_word_t pc;
    csr_pkg::csr_word_t cause;
    csr_pkg::csr_word_t tval;
    csr_pkg::csr_word_t target;
    csr_pkg::csr_word_t data;
    csr_pkg::csr_word_t wdata;
    csr_pkg::mstatus_u  exp_status;
    csr_pkg::mstatus_u  act_status;
    logic               err;
    test_name = "trap_entry";
    wdata = rand_word();
    apb_write(`CSR_ADDR_MTVEC, wdata, err);
    check_resp("mtvec write", 1'b0, err);
    shadow[`CSR_SLOT_MTVEC] = expect_write(`CSR_SLOT_MTVEC, wdata);
    apb_write(`CSR_ADDR_MSTATUS, 64'h1808, err);  // mie set, mpp machine
    check_resp("mstatus write", 1'b0, err);
    shadow[`CSR_SLOT_MSTATUS] = expect_write(`CSR_SLOT_MSTATUS, 64'h1808);
    pc    = rand_word();
    cause = rand_word();
    tval  = rand_word();
    trap_enter(pc, cause, tval, target);
    check_word("redirect_pc", shadow[`CSR_SLOT_MTVEC] & ~64'h3, target);
    exp_status.raw         = shadow[`CSR_SLOT_MSTATUS];
    exp_status.fields.mpie = exp_status.fields.mie;
    exp_status.fields.mie  = 1'b0;
    exp_status.fields.mpp  = 2'b11;
    shadow[`CSR_SLOT_MSTATUS] = exp_status.raw;
    shadow[`CSR_SLOT_MEPC]    = pc & ~64'h3;
    shadow[`CSR_SLOT_MCAUSE]  = cause;
    shadow[`CSR_SLOT_MTVAL]   = tval;
    apb_read(`CSR_ADDR_MEPC, data, err);
    check_word("mepc", shadow[`CSR_SLOT_MEPC], data);
    apb_read(`CSR_ADDR_MCAUSE, data, err);
    check_word("mcause", shadow[`CSR_SLOT_MCAUSE], data);
    apb_read(`CSR_ADDR_MTVAL, data, err);
    check_word("mtval", shadow[`CSR_SLOT_MTVAL], data);
    apb_read(`CSR_ADDR_MSTATUS, act_status.raw, err);
    check_mstatus(exp_status, act_status);
  endtask

  task automatic return_from_trap();
    csr_pkg::csr_word_t target;
    csr_pkg::mstatus_u  exp_status;
    csr_pkg::mstatus_u  act_status;
    logic               err;
    test_name = "trap_exit";
    trap_exit(target);
    check_word("redirect_pc", shadow[`CSR_SLOT_MEPC], target);
    exp_status.raw         = shadow[`CSR_SLOT_MSTATUS];
    exp_status.fields.mie  = exp_status.fields.mpie;  // Pop the enable stack
    exp_status.fields.mpie = 1'b1;
    apb_read(`CSR_ADDR_MSTATUS, act_status.raw, err);
    check_mstatus(exp_status, act_status);
  endtask

  task automatic count_cycles();
    csr_pkg::csr_word_t first;
    csr_pkg::csr_word_t second;
    csr_pkg::csr_word_t data;
    logic               err;
    test_name = "mcycle";
    apb_read(`CSR_ADDR_MCYCLE, first, err);
    check_resp("mcycle read", 1'b0, err);
    repeat (4) apb_read(`CSR_ADDR_MSCRATCH, data, err);
    apb_read(`CSR_ADDR_MCYCLE, second, err);
    if (first == 64'h0 || second <= first) begin
      stop_run($sformatf("mcycle did not count up: first read %0d, second read %0d",
                         first, second));
    end
  endtask

  initial begin
    void'($urandom(24));
    rst     = 1'b1;
    apb_req = '0;
    trap    = '0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;
    read_reset_values();
    write_masked_values();
    provoke_bus_errors();
    take_trap();
    return_from_trap();
    count_cycles();
    $display("=== PASS ===");
    $finish;
  end

endmodule
